//--- design/keypad_pkg.sv
/*
 * Keypad shared definitions
 * Key code and row number types, config register map
 */
`default_nettype none

package keypad_pkg;

    // ==================================================
    // Key and row types
    // ==================================================
    typedef logic [3:0] key_code_t;             // row*4 + column
    typedef logic [1:0] row_sel_t;              // Row being scanned

    // ==================================================
    // Config register map
    // ==================================================
    localparam int CFG_DW = 16;                 // Config bus width

    // Scan dwell period, in clocks minus one
    localparam logic CFG_ADDR_PERIOD   = 1'b0;
    // Debounce frames in [3:0], scan enable in [15]
    localparam logic CFG_ADDR_DEBOUNCE = 1'b1;

endpackage

`default_nettype wire

//--- design/scan_if.sv
/*
 * Row sample bus, scanner to decoder
 */
`timescale 1ns/1ps
`default_nettype none

interface scan_if;

    logic                  sample;     // One-cycle pulse per row dwell
    keypad_pkg::row_sel_t  row;        // Row the sample belongs to
    logic [3:0]            cols;       // Synced columns, active low
    logic                  frame_end;  // Set with the row 3 sample

    // Scanner side
    modport src (
        output sample, row, cols, frame_end
    );

    // Decoder side
    modport dst (
        input  sample, row, cols, frame_end
    );

endinterface

`default_nettype wire

//--- design/keypad_cfg.sv
/*
 * Keypad config registers
 * Row dwell period, debounce frame count and scan enable, with readback
 */
`timescale 1ns/1ps
`default_nettype none

module keypad_cfg #(
    parameter int CNT_W        = 16,
    parameter int RESET_PERIOD = 7
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_we,
    input  logic                          cfg_addr,
    input  logic [keypad_pkg::CFG_DW-1:0] cfg_wdata,
    output logic [keypad_pkg::CFG_DW-1:0] cfg_rdata,
    output logic [CNT_W-1:0]              scan_period,
    output logic [3:0]                    deb_frames,
    output logic                          scan_en
);

    // ==================================================
    // Register writes
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_period <= CNT_W'(RESET_PERIOD);
            deb_frames  <= 4'd2;                // Two matching frames
            scan_en     <= 1'b1;                // Scanning from reset
        end else if (cfg_we) begin
            if (cfg_addr == keypad_pkg::CFG_ADDR_PERIOD) begin
                scan_period <= CNT_W'(cfg_wdata);
            end else begin
                deb_frames <= cfg_wdata[3:0];
                scan_en    <= cfg_wdata[keypad_pkg::CFG_DW-1];
            end
        end
    end

    // ==================================================
    // Readback, combinational
    // ==================================================
    always_comb begin
        case (cfg_addr)
            keypad_pkg::CFG_ADDR_DEBOUNCE:
                cfg_rdata = {scan_en, {(keypad_pkg::CFG_DW-5){1'b0}}, deb_frames};
            default:
                cfg_rdata = keypad_pkg::CFG_DW'(scan_period);
        endcase
    end

    // Below 3 the column sync has not settled at sample time
    a_period_min: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cfg_we && cfg_addr == keypad_pkg::CFG_ADDR_PERIOD) |=> (scan_period >= CNT_W'(3))
    ) else $error("scan period written below 3");

endmodule

`default_nettype wire

//--- design/keypad_scanner.sv
/*
 * Keypad row scanner
 * Drives one row low per dwell, syncs the columns, issues one sample per row
 */
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             scan_en,
    input  logic [CNT_W-1:0] scan_period,  // Dwell is scan_period+1 clocks
    input  logic [3:0]       col_n,        // Async, pulled up
    output logic [3:0]       row_n,        // One row low at a time
    scan_if.src              scan
);

    logic [CNT_W-1:0]     dwell_cnt;
    keypad_pkg::row_sel_t row_q;
    logic                 dwell_last;
    logic [3:0]           col_sync1;
    logic [3:0]           col_sync2;

    // ==================================================
    // Column synchronizer
    // ==================================================
    // Two flops, idle value is all released
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_sync1 <= 4'b1111;
            col_sync2 <= 4'b1111;
        end else begin
            col_sync1 <= col_n;
            col_sync2 <= col_sync1;
        end
    end

    // ==================================================
    // Dwell counter and row sequencer
    // ==================================================
    // >= so a smaller period written mid-dwell ends it at once
    assign dwell_last = (dwell_cnt >= scan_period);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            row_q     <= '0;
        end else if (!scan_en) begin
            dwell_cnt <= '0;                    // Hold at row 0
            row_q     <= '0;
        end else if (dwell_last) begin
            dwell_cnt <= '0;
            row_q     <= row_q + 2'd1;          // Wraps 3 -> 0
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Active low row drive, all released when disabled
    always_comb begin
        if (scan_en) begin
            row_n = ~(4'b0001 << row_q);
        end else begin
            row_n = 4'b1111;
        end
    end

    // ==================================================
    // Sample bus
    // ==================================================
    // Last dwell cycle, sync2 has held this row for 2+ clocks
    assign scan.sample    = scan_en && dwell_last;
    assign scan.row       = row_q;
    assign scan.cols      = col_sync2;
    assign scan.frame_end = scan_en && dwell_last && (row_q == 2'd3);

    // Low bit walks to the next row after each sample
    a_row_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan.sample |=> (!scan_en || row_n == {$past(row_n[2:0]), $past(row_n[3])})
    ) else $error("row_n did not step to the next row after a sample");

    // Counter restarts after a sample, so never two in a row
    a_one_sample: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan.sample |=> !scan.sample
    ) else $error("sample pulsed on two consecutive cycles");

endmodule

`default_nettype wire

//--- design/key_decoder.sv
/*
 * Keypad frame decoder
 * Single-key check per frame, debounce over frames, key strobe and key-down level
 */
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  scan_en,
    input  logic [3:0]            deb_frames,
    scan_if.dst                   scan,
    output logic                  key_valid,
    output keypad_pkg::key_code_t key_code,
    output logic                  key_down
);

    logic [2:0]            row_keys;       // Closed switches in this row
    logic [1:0]            row_col;        // Lowest closed column
    logic [1:0]            keys_q;         // 0, 1, or 2 for many
    logic [1:0]            keys_nx;
    keypad_pkg::key_code_t first_code_q;   // First key seen this frame
    keypad_pkg::key_code_t code_nx;
    keypad_pkg::key_code_t cand_code_q;    // Key under debounce
    logic                  cand_valid_q;
    logic [3:0]            deb_cnt_q;
    logic [3:0]            deb_nx;
    logic                  frame_done;
    logic                  fire;

    // ==================================================
    // Frame accumulation, current row included
    // ==================================================
    assign row_keys = 3'($countones(~scan.cols));

    always_comb begin
        row_col = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!scan.cols[i]) row_col = 2'(i);  // Lowest low bit wins
        end
    end

    // Saturate at 2, more than one key is all that matters
    assign keys_nx = (({1'b0, keys_q} + row_keys) > 3'd1) ? 2'd2 : 2'(keys_q + row_keys);
    assign code_nx = (keys_q == 2'd0 && row_keys != 3'd0) ? {scan.row, row_col}
                                                          : first_code_q;

    assign frame_done = scan.sample && scan.frame_end;

    // Same key as last frame counts on, else restart at 1
    assign deb_nx = (cand_valid_q && cand_code_q == code_nx)
                  ? ((deb_cnt_q == 4'hF) ? deb_cnt_q : deb_cnt_q + 4'd1)
                  : 4'd1;
    assign fire = frame_done && (keys_nx == 2'd1) && (deb_nx >= deb_frames) && !key_down;

    // ==================================================
    // Control state
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keys_q       <= 2'd0;
            cand_valid_q <= 1'b0;
            deb_cnt_q    <= 4'd0;
            key_valid    <= 1'b0;
            key_down     <= 1'b0;
        end else if (!scan_en) begin
            keys_q       <= 2'd0;               // Drop everything
            cand_valid_q <= 1'b0;
            deb_cnt_q    <= 4'd0;
            key_valid    <= 1'b0;
            key_down     <= 1'b0;
        end else begin
            key_valid <= fire;                  // One-cycle strobe
            if (fire) key_down <= 1'b1;
            if (frame_done) begin
                keys_q <= 2'd0;                 // New frame
                case (keys_nx)
                    2'd0: begin                 // Empty frame, released
                        key_down     <= 1'b0;
                        cand_valid_q <= 1'b0;
                        deb_cnt_q    <= 4'd0;
                    end
                    2'd1: begin
                        cand_valid_q <= 1'b1;
                        deb_cnt_q    <= deb_nx;
                    end
                    default: begin              // Ghosting risk, no candidate
                        cand_valid_q <= 1'b0;
                        deb_cnt_q    <= 4'd0;
                    end
                endcase
            end else if (scan.sample) begin
                keys_q <= keys_nx;
            end
        end
    end

    // Key codes
    always_ff @(posedge clk) begin
        if (scan.sample) first_code_q <= code_nx;
        if (frame_done && keys_nx == 2'd1) cand_code_q <= code_nx;
        if (fire) key_code <= code_nx;
    end

    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_valid |=> !key_valid
    ) else $error("key_valid high on two consecutive cycles");

endmodule

`default_nettype wire

//--- design/keypad_top.sv
/*
 * 4x4 keypad controller top
 * Config registers, row scanner and frame decoder
 */
`timescale 1ns/1ps
`default_nettype none

module keypad_top #(
    parameter int CNT_W        = 16,
    parameter int RESET_PERIOD = 7
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [3:0]                    row_n,
    input  logic [3:0]                    col_n,
    input  logic                          cfg_we,
    input  logic                          cfg_addr,
    input  logic [keypad_pkg::CFG_DW-1:0] cfg_wdata,
    output logic [keypad_pkg::CFG_DW-1:0] cfg_rdata,
    output logic                          key_valid,
    output keypad_pkg::key_code_t         key_code,
    output logic                          key_down
);

    logic [CNT_W-1:0] scan_period;
    logic [3:0]       deb_frames;
    logic             scan_en;

    scan_if scan_bus ();                        // Scanner to decoder

    keypad_cfg #(.CNT_W(CNT_W), .RESET_PERIOD(RESET_PERIOD)) u_cfg (
        .clk, .rst_n, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .scan_period, .deb_frames, .scan_en
    );

    keypad_scanner #(.CNT_W(CNT_W)) u_scan (
        .clk, .rst_n, .scan_en, .scan_period, .col_n, .row_n,
        .scan (scan_bus.src)
    );

    key_decoder u_dec (
        .clk, .rst_n, .scan_en, .deb_frames,
        .scan (scan_bus.dst),
        .key_valid, .key_code, .key_down
    );

endmodule

`default_nettype wire

//--- bench/tb_keypad.sv
/*
 * Keypad controller testbench
 * Switch-matrix model, random keys, row and key event assertions
 */
`timescale 1ns/1ps
`default_nettype none

module tb_keypad;

    localparam int CLK_PERIOD  = 100;           // ns
    localparam int MAX_PERIOD  = 11;            // Largest dwell period used
    localparam int TEST_FRAMES = 79;            // Sum of all waits below
    localparam int WATCHDOG_NS = TEST_FRAMES * 4 * (MAX_PERIOD + 1) * CLK_PERIOD
                               + 500 * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [3:0]  row_n;
    logic [3:0]  col_n;
    logic        cfg_we;
    logic        cfg_addr;
    logic [15:0] cfg_wdata;
    logic [15:0] cfg_rdata;
    logic        key_valid;
    logic [3:0]  key_code;
    logic        key_down;

    int          seed = 10;
    logic [15:0] pressed;                       // One bit per key, row*4 + column
    int          cur_period;                    // Dwell period as last written
    logic        scan_on;                       // Enable as last written
    logic        allow_valid;                   // Key strobe allowed now
    logic        key_held;                      // Single key held, strobe expected
    logic [3:0]  exp_code;
    logic        rd_check;
    logic [15:0] rd_expect;
    int          valid_cnt;                     // key_valid pulses since start
    logic [3:0]  row_prev;                      // Row pattern one cycle ago
    int          run_len;                       // Cycles row_prev has held
    logic [3:0]  code;

    keypad_top dut0 (
        .clk, .rst_n, .row_n, .col_n, .cfg_we, .cfg_addr, .cfg_wdata,
        .cfg_rdata, .key_valid, .key_code, .key_down
    );

    // Switch matrix, pulled up columns
    always_comb begin
        col_n = 4'hF;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (pressed[r * 4 + c] && !row_n[r]) col_n[c] = 1'b0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("Watchdog timeout, the tests did not finish in time");
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // ==================================================
    // Monitors and assertions
    // ==================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_prev <= 4'hF;
            run_len  <= 0;
        end else begin
            row_prev <= row_n;
            run_len  <= (row_n == row_prev) ? run_len + 1 : 1;
        end
    end

    always @(posedge clk) begin
        if (key_valid) valid_cnt <= valid_cnt + 1;
    end

    a_row_start: assert property (@(posedge clk) disable iff (!rst_n)
        (row_n != 4'hF && row_prev == 4'hF) |-> row_n == 4'b1110)
        else stop_run($sformatf("[FAIL] row_n 0x%h, expected 0xe", $sampled(row_n)));
    a_row_order: assert property (@(posedge clk) disable iff (!rst_n)
        (row_n != 4'hF && row_prev != 4'hF && row_n != row_prev)
        |-> row_n == {row_prev[2:0], row_prev[3]})
        else stop_run($sformatf("[FAIL] row_n 0x%h after 0x%h", $sampled(row_n),
                                $sampled(row_prev)));
    a_row_dwell: assert property (@(posedge clk) disable iff (!rst_n)
        (row_n != 4'hF && row_prev != 4'hF && row_n != row_prev)
        |-> run_len == cur_period + 1)
        else stop_run($sformatf("[FAIL] row dwell 0x%h, expected 0x%h",
                                $sampled(run_len), $sampled(cur_period) + 1));
    a_row_long: assert property (@(posedge clk) disable iff (!rst_n)
        (row_n != 4'hF && row_n == row_prev) |-> run_len <= cur_period)
        else stop_run($sformatf("[FAIL] row_n 0x%h held longer than 0x%h cycles",
                                $sampled(row_n), $sampled(cur_period) + 1));
    a_row_off: assert property (@(posedge clk) disable iff (!rst_n)
        !scan_on |-> row_n == 4'hF)
        else stop_run($sformatf("[FAIL] row_n 0x%h, expected 0xf", $sampled(row_n)));
    a_valid_ok: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> allow_valid)
        else stop_run("key_valid pulsed where no key event was expected");
    a_code: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> key_code == exp_code)
        else stop_run($sformatf("[FAIL] key_code 0x%h, expected 0x%h",
                                $sampled(key_code), $sampled(exp_code)));
    a_down_set: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> key_down)
        else stop_run("[FAIL] key_down 0x0 with key_valid, expected 0x1");
    a_down_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(key_down) |-> key_valid)
        else stop_run("key_down rose without a key_valid pulse");
    a_down_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (key_down && key_held) |=> key_down)
        else stop_run("[FAIL] key_down 0x0 while the key is held, expected 0x1");
    a_down_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !allow_valid |-> !key_down)
        else stop_run("[FAIL] key_down 0x1 with no key accepted, expected 0x0");
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        rd_check |-> cfg_rdata == rd_expect)
        else stop_run($sformatf("[FAIL] cfg_rdata 0x%h, expected 0x%h",
                                $sampled(cfg_rdata), $sampled(rd_expect)));

    // ==================================================
    // Stimulus tasks, all start and end on a falling edge
    // ==================================================
    task automatic wait_frames(input int frames);
        repeat (frames * 4 * (cur_period + 1)) @(negedge clk);
    endtask

    task automatic cfg_write(input logic addr, input logic [15:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
        if (addr == 1'b0) cur_period = int'(data);  // Period register
        else scan_on = data[15];                     // Debounce and enable
    endtask

    task automatic read_back(input logic addr, input logic [15:0] expect_val);
        cfg_addr  = addr;
        rd_expect = expect_val;
        rd_check  = 1'b1;
        @(negedge clk);
        rd_check = 1'b0;
    endtask

    task automatic pick_key(output logic [3:0] key);
        int r;
        int c;
        r   = $random(seed) & 3;
        c   = $random(seed) & 3;
        key = 4'(r * 4 + c);                    // Row times four plus column
    endtask

    // Hold keys for whole frames, then release and let three frames pass
    task automatic press_and_release(input logic [15:0] keys, input int frames,
                                     input logic fires, input logic [3:0] key);
        int start_cnt;
        start_cnt   = valid_cnt;
        allow_valid = fires;
        key_held    = fires;
        exp_code    = key;
        pressed     = keys;
        wait_frames(frames);
        pressed  = 16'h0000;
        key_held = 1'b0;
        wait_frames(3);
        assert ((valid_cnt - start_cnt) == (fires ? 1 : 0))
            else stop_run($sformatf("[FAIL] key_valid pulses 0x%h, expected 0x%h",
                                    valid_cnt - start_cnt, fires ? 1 : 0));
        assert (!key_down)
            else stop_run("[FAIL] key_down 0x1 after release, expected 0x0");
        allow_valid = 1'b0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        rst_n       = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = 1'b0;
        cfg_wdata   = 16'h0000;
        pressed     = 16'h0000;
        cur_period  = 7;                        // Reset value of the period
        scan_on     = 1'b1;
        allow_valid = 1'b0;
        key_held    = 1'b0;
        exp_code    = 4'h0;
        rd_check    = 1'b0;
        rd_expect   = 16'h0000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_back(1'b0, 16'd7);
        wait_frames(3);                         // Rows at reset period
        repeat (4) begin
            pick_key(code);
            press_and_release(16'(1) << code, 4, 1'b1, code);
        end
        pick_key(code);
        press_and_release(16'(1) << code, 1, 1'b0, code);   // Too short
        pick_key(code);
        press_and_release((16'(1) << code) | (16'(1) << (code ^ 4'b0101)), 4, 1'b0, code);

        cfg_write(1'b1, 16'h8004);              // Four frames, enabled
        read_back(1'b1, 16'h8004);
        pick_key(code);
        press_and_release(16'(1) << code, 3, 1'b0, code);
        press_and_release(16'(1) << code, 5, 1'b1, code);

        cfg_write(1'b1, 16'h0004);              // Scan off
        read_back(1'b1, 16'h0004);
        press_and_release(16'(1) << code, 3, 1'b0, code);
        cfg_write(1'b0, 16'd11);
        read_back(1'b0, 16'd11);
        cfg_write(1'b1, 16'h8002);              // Back on, two frames
        wait_frames(3);                         // Rows at the new period
        repeat (2) begin
            pick_key(code);
            press_and_release(16'(1) << code, 4, 1'b1, code);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- keypad.f
design/keypad_pkg.sv
design/scan_if.sv
design/keypad_cfg.sv
design/keypad_scanner.sv
design/key_decoder.sv
design/keypad_top.sv
bench/tb_keypad.sv

//--- run_sim.sh
#!/bin/sh
# Build the keypad testbench with Verilator and run it
# A $fatal in the testbench gives a non-zero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f keypad.f --top-module tb_keypad -o tb_keypad

./obj_dir/tb_keypad
